//--- Bender.yml
package:
  name: fsqrt

sources:
  - files:
      - fsqrt_pkg.sv
      - coef_rom.sv
      - pipe_delay.sv
      - fmul_pipe.sv
      - fadd_pipe.sv
      - fsqrt_pipe.sv
      - fsqrt_ctrl.sv
      - fsqrt_unit.sv
  - target: test
    files:
      - fsqrt_checker.sv
      - fsqrt_sva.sv
      - tb_fsqrt.sv

//--- coef_rom.sv
`timescale 1ns/1ps

module coef_rom import fsqrt_pkg::*; #(
    parameter int ADDR_W  = ODD_ADDR_W,
    parameter int DEPTH   = ODD_DEPTH,
    parameter bit ODD_EXP = 1'b1,
    parameter bit SLOPE   = 1'b1
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] addr,
    output logic [FP_W-1:0]   q
);

    logic [FP_W-1:0] mem [DEPTH];

    // double to single, rounded on the dropped bits.
    function automatic logic [FP_W-1:0] to_single(input real v);
        logic [63:0] d;
        logic [10:0] e;
        d = $realtobits(v) + 64'h0000_0000_1000_0000;
        e = d[62:52] - 11'd896;
        return {d[63], e[EXP_W-1:0], d[51:29]};
    endfunction

    // chord of sqrt across each segment.
    initial begin
        real base, lo, hi, a, b;
        base = ODD_EXP ? 1.0 : 2.0;
        for (int i = 0; i < DEPTH; i++) begin
            lo = base * (1.0 + real'(i) / real'(DEPTH));
            hi = base * (1.0 + real'(i + 1) / real'(DEPTH));
            a = ($sqrt(hi) - $sqrt(lo)) / (hi - lo);
            b = $sqrt(lo) - a * lo;
            mem[i] = to_single(SLOPE ? a : b);
        end
    end

    always_ff @(posedge clk) begin
        q <= mem[addr];
    end

endmodule

//--- fadd_pipe.sv
`timescale 1ns/1ps

module fadd_pipe import fsqrt_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic [FP_W-1:0] x,
    input  logic [FP_W-1:0] y,
    output logic [FP_W-1:0] res
);

    logic                 x_big;
    logic [FP_W-2:0]      big_mag, small_mag;
    logic [EXP_W-1:0]     shamt;
    logic [MAN_W+2:0]     small_al;
    logic                 s1_sign, s1_sub;
    logic [EXP_W-1:0]     s1_exp;
    logic [MAN_W+2:0]     s1_big, s1_small;
    logic [MAN_W+3:0]     sum;
    logic [MAN_W+2:0]     norm;
    logic [4:0]           lz;

    // leading zeros of the 26-bit sum without its carry bit.
    function automatic logic [4:0] lzc(input logic [MAN_W+2:0] v);
        logic [4:0] n;
        n = 5'(MAN_W + 3);
        for (int i = 0; i <= MAN_W + 2; i++) begin
            if (v[i]) n = 5'(MAN_W + 2 - i);
        end
        return n;
    endfunction

    always_comb begin
        x_big     = x[FP_W-2:0] >= y[FP_W-2:0];
        big_mag   = x_big ? x[FP_W-2:0] : y[FP_W-2:0];
        small_mag = x_big ? y[FP_W-2:0] : x[FP_W-2:0];
        shamt     = big_mag[FP_W-2:MAN_W] - small_mag[FP_W-2:MAN_W];
        // two guard bits below the lsb.
        small_al  = {small_mag[FP_W-2:MAN_W] != '0, small_mag[MAN_W-1:0], 2'b00} >> shamt;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_sign  <= 1'b0;
            s1_sub   <= 1'b0;
            s1_exp   <= '0;
            s1_big   <= '0;
            s1_small <= '0;
        end else begin
            s1_sign  <= x_big ? x[FP_W-1] : y[FP_W-1];
            s1_sub   <= x[FP_W-1] ^ y[FP_W-1];
            s1_exp   <= big_mag[FP_W-2:MAN_W];
            s1_big   <= {big_mag[FP_W-2:MAN_W] != '0, big_mag[MAN_W-1:0], 2'b00};
            s1_small <= small_al;
        end
    end

    always_comb begin
        if (s1_sub) begin
            sum = {1'b0, s1_big} - {1'b0, s1_small};
        end else begin
            sum = {1'b0, s1_big} + {1'b0, s1_small};
        end
        lz   = lzc(sum[MAN_W+2:0]);
        norm = sum[MAN_W+2:0] << lz;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            res <= '0;
        end else if (sum[MAN_W+3]) begin
            res <= {s1_sign, s1_exp + 1'b1, sum[MAN_W+2 -: MAN_W]}; // carry out.
        end else if (sum == '0 || {3'b000, lz} >= s1_exp) begin
            res <= '0;
        end else begin
            res <= {s1_sign, s1_exp - lz, norm[MAN_W+1 -: MAN_W]};
        end
    end

endmodule

//--- flist.f
fsqrt_pkg.sv
coef_rom.sv
pipe_delay.sv
fmul_pipe.sv
fadd_pipe.sv
fsqrt_pipe.sv
fsqrt_ctrl.sv
fsqrt_unit.sv
fsqrt_checker.sv
fsqrt_sva.sv
tb_fsqrt.sv

//--- fmul_pipe.sv
`timescale 1ns/1ps

module fmul_pipe import fsqrt_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic [FP_W-1:0] x,
    input  logic [FP_W-1:0] y,
    output logic [FP_W-1:0] res
);

    logic                 s1_sign, s1_zero;
    logic [EXP_W+1:0]     s1_exp;
    logic [2*MAN_W+1:0]   s1_prod;
    logic [EXP_W+1:0]     s2_exp;
    logic [MAN_W-1:0]     s2_man;

    // exponent sum and full significand product.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_sign <= 1'b0;
            s1_zero <= 1'b1;
            s1_exp  <= '0;
            s1_prod <= '0;
        end else begin
            s1_sign <= x[FP_W-1] ^ y[FP_W-1];
            s1_zero <= (x[FP_W-2:MAN_W] == '0) || (y[FP_W-2:MAN_W] == '0);
            s1_exp  <= {2'b00, x[FP_W-2:MAN_W]} + {2'b00, y[FP_W-2:MAN_W]};
            s1_prod <= {1'b1, x[MAN_W-1:0]} * {1'b1, y[MAN_W-1:0]};
        end
    end

    // product is in [1,4), so at most one bit of shift.
    always_comb begin
        if (s1_prod[2*MAN_W+1]) begin
            s2_man = s1_prod[2*MAN_W -: MAN_W];
            s2_exp = s1_exp - (EXP_W+2)'(EXP_BIAS - 1);
        end else begin
            s2_man = s1_prod[2*MAN_W-1 -: MAN_W];
            s2_exp = s1_exp - (EXP_W+2)'(EXP_BIAS);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            res <= '0;
        end else begin
            res <= s1_zero ? '0 : {s1_sign, s2_exp[EXP_W-1:0], s2_man}; // truncated.
        end
    end

endmodule

//--- fsqrt_checker.sv
`timescale 1ns/1ps

module fsqrt_checker import fsqrt_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic            in_valid,
    input  logic [FP_W-1:0] x,
    input  logic            has_ref,
    input  logic [FP_W-1:0] ref_val,
    input  logic            in_credit,
    input  logic            out_credit,
    input  logic            out_valid,
    input  logic [FP_W-1:0] res,
    output int              n_acc,
    output int              n_icr,
    output int              n_res,
    output int              n_err
);

    localparam int ULP_TOL = 8;

    logic [FP_W-1:0] op_q [$];
    logic [FP_W-1:0] exp_q [$];
    logic            seen_in = 1'b0;
    int              out_owed;

    function automatic real to_real(input logic [FP_W-1:0] f);
        return $bitstoreal({f[31], 11'(f[30:23]) + 11'd896, f[22:0], 29'd0});
    endfunction

    // rounds to the nearest normal single.
    function automatic logic [FP_W-1:0] to_float(input real r);
        logic [63:0] d;
        logic [30:0] mag;
        d   = $realtobits(r);
        mag = {8'(d[62:52] - 11'd896), d[51:29]};
        return {d[63], mag + 31'(d[28])};
    endfunction

    function automatic logic [FP_W-1:0] sqrt_ref(input logic [FP_W-1:0] f);
        if (f[30:23] == '0) begin
            return '0; // zero and denormals.
        end
        return to_float($sqrt(to_real(f)));
    endfunction

    always @(posedge clk) begin : watch
        logic [FP_W-1:0] op_v, exp_v, diff;
        if (!rstn) begin
            op_q.delete();
            exp_q.delete();
            out_owed = 0;
        end else begin
            if (!seen_in && (out_valid || in_credit)) begin
                $display("out_valid or in_credit went high before any operand was sent");
                n_err++;
            end
            if (in_valid) begin
                seen_in = 1'b1;
                op_q.push_back(x);
                exp_q.push_back(has_ref ? ref_val : sqrt_ref(x));
                n_acc++;
            end
            n_icr += int'(in_credit);
            if (n_icr > n_acc) begin
                $display("in_credit pulsed more often than operands were sent");
                n_err++;
            end
            if (out_valid && op_q.size() == 0) begin
                $display("a result appeared with no operand outstanding");
                n_err++;
            end else if (out_valid) begin
                op_v  = op_q.pop_front();
                exp_v = exp_q.pop_front();
                diff  = (res > exp_v) ? res - exp_v : exp_v - res; // distance in ulps.
                if ((exp_v == '0) ? (res != '0) : (diff > ULP_TOL)) begin
                    $display("FAILED res op=%h got=%h expected=%h", op_v, res, exp_v);
                    n_err++;
                end
            end
            n_res    += int'(out_valid);
            out_owed += int'(out_valid) - int'(out_credit);
            if (out_owed > OUT_CREDITS) begin
                $display("more than %0d results delivered without credits returned",
                         OUT_CREDITS);
                n_err++;
            end
        end
    end

endmodule

//--- fsqrt_ctrl.sv
`timescale 1ns/1ps

module fsqrt_ctrl import fsqrt_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic            in_valid,
    input  logic [FP_W-1:0] x,
    output logic            in_credit,
    input  logic            out_credit,
    output logic            issue,
    output logic [FP_W-1:0] op,
    output logic            out_valid
);

    logic [FP_W-1:0]     fifo_mem [IN_DEPTH];
    logic [IN_PTR_W-1:0] wr_ptr, rd_ptr;
    logic [IN_PTR_W:0]   fifo_cnt;
    logic [CREDIT_W-1:0] credit_cnt;
    logic [SQRT_LAT-1:0] vld_sr;

    // issue only when downstream room is guaranteed.
    assign issue     = (fifo_cnt != '0) && (credit_cnt != '0);
    assign op        = fifo_mem[rd_ptr];
    assign in_credit = issue;
    assign out_valid = vld_sr[SQRT_LAT-1];

    always_ff @(posedge clk) begin
        if (in_valid) begin
            fifo_mem[wr_ptr] <= x; // upstream credits keep this from overflowing.
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_cnt   <= '0;
            credit_cnt <= CREDIT_W'(OUT_CREDITS);
            vld_sr     <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fifo_cnt   <= fifo_cnt + (IN_PTR_W+1)'(in_valid) - (IN_PTR_W+1)'(issue);
            credit_cnt <= credit_cnt + CREDIT_W'(out_credit) - CREDIT_W'(issue);
            vld_sr     <= {vld_sr[SQRT_LAT-2:0], issue}; // tracks the datapath.
        end
    end

endmodule

//--- fsqrt_pipe.sv
`timescale 1ns/1ps

module fsqrt_pipe import fsqrt_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic            issue,
    input  logic [FP_W-1:0] op,
    output logic [FP_W-1:0] res
);

    logic                   op_sign;
    logic [EXP_W-1:0]       op_exp;
    logic [MAN_W-1:0]       op_man;
    logic [EXP_W:0]         exp_unb;
    logic [ODD_ADDR_W-1:0]  addr_odd;
    logic [EVEN_ADDR_W-1:0] addr_even;
    logic [FP_W-1:0]        a_odd, b_odd, a_even, b_even;
    logic [MAN_W-1:0]       man_q;
    logic                   odd_q;
    logic [FP_W-1:0]        coef_a, coef_b, coef_b_d, m_op, prod, sum;
    side_t                  side_in, side_out;
    logic                   res_sign, res_zero;
    logic [EXP_W-1:0]       res_hexp;

    assign {op_sign, op_exp, op_man} = op;
    assign exp_unb   = {1'b0, op_exp} - (EXP_W+1)'(EXP_BIAS);
    assign addr_odd  = op_man[MAN_W-1 -: ODD_ADDR_W];
    assign addr_even = op_man[MAN_W-1 -: EVEN_ADDR_W];
    assign side_in   = {op_sign, op_exp == '0, exp_unb[EXP_W:1]}; // floor(e/2).

    coef_rom #(.ADDR_W(ODD_ADDR_W), .DEPTH(ODD_DEPTH), .ODD_EXP(1'b1), .SLOPE(1'b1)) a_odd_i (
        .clk(clk), .addr(addr_odd), .q(a_odd)
    );
    coef_rom #(.ADDR_W(ODD_ADDR_W), .DEPTH(ODD_DEPTH), .ODD_EXP(1'b1), .SLOPE(1'b0)) b_odd_i (
        .clk(clk), .addr(addr_odd), .q(b_odd)
    );
    coef_rom #(.ADDR_W(EVEN_ADDR_W), .DEPTH(EVEN_DEPTH), .ODD_EXP(1'b0), .SLOPE(1'b1)) a_even_i (
        .clk(clk), .addr(addr_even), .q(a_even)
    );
    coef_rom #(.ADDR_W(EVEN_ADDR_W), .DEPTH(EVEN_DEPTH), .ODD_EXP(1'b0), .SLOPE(1'b0)) b_even_i (
        .clk(clk), .addr(addr_even), .q(b_even)
    );

    // lines up with the rom read.
    always_ff @(posedge clk) begin
        if (issue) begin
            man_q <= op_man;
            odd_q <= op_exp[0];
        end
    end

    assign coef_a = odd_q ? a_odd : a_even;
    assign coef_b = odd_q ? b_odd : b_even;
    // m in [1,2) for odd biased exponent, else [2,4).
    assign m_op = {1'b0, odd_q ? EXP_W'(EXP_BIAS) : EXP_W'(EXP_BIAS + 1), man_q};

    fmul_pipe mul_i (
        .clk(clk), .rstn(rstn), .x(coef_a), .y(m_op), .res(prod)
    );

    pipe_delay #(.payload_t(logic [FP_W-1:0]), .DEPTH(LAT_MUL)) b_dly_i (
        .clk(clk), .rstn(rstn), .d(coef_b), .q(coef_b_d)
    );

    fadd_pipe add_i (
        .clk(clk), .rstn(rstn), .x(coef_b_d), .y(prod), .res(sum)
    );

    pipe_delay #(.payload_t(side_t), .DEPTH(SQRT_LAT)) side_dly_i (
        .clk(clk), .rstn(rstn), .d(side_in), .q(side_out)
    );

    // a*m+b sits in [1,2), only its mantissa is kept.
    assign {res_sign, res_zero, res_hexp} = side_out;
    assign res = res_zero ? '0 : {res_sign, res_hexp + EXP_W'(EXP_BIAS), sum[MAN_W-1:0]};

endmodule

//--- fsqrt_pkg.sv
package fsqrt_pkg;

    // float format.
    localparam int FP_W     = 32;
    localparam int EXP_W    = 8;
    localparam int MAN_W    = 23;
    localparam int EXP_BIAS = 127;

    // coefficient tables, odd exponent covers [1,2), even covers [2,4).
    localparam int ODD_ADDR_W  = 9;
    localparam int ODD_DEPTH   = 512;
    localparam int EVEN_ADDR_W = 10;
    localparam int EVEN_DEPTH  = 1024;

    localparam int LAT_ROM  = 1;
    localparam int LAT_MUL  = 2;
    localparam int LAT_ADD  = 2;
    localparam int SQRT_LAT = LAT_ROM + LAT_MUL + LAT_ADD;

    // flow control.
    localparam int IN_DEPTH    = 4;
    localparam int IN_PTR_W    = 2;
    localparam int OUT_CREDITS = 8;
    localparam int CREDIT_W    = 4;

    // sign, zero flag, halved unbiased exponent.
    localparam int SIDE_W = 2 + EXP_W;
    typedef logic [SIDE_W-1:0] side_t;

endpackage

//--- fsqrt_sva.sv
`timescale 1ns/1ps

module fsqrt_sva import fsqrt_pkg::*; (
    input logic                clk,
    input logic                rstn,
    input logic                issue,
    input logic                out_credit,
    input logic                out_valid,
    input logic [CREDIT_W-1:0] credit_cnt
);

    int n_issue, n_ret, n_out;
    int sva_errs;

    always @(posedge clk) begin
        if (!rstn) begin
            n_issue <= 0;
            n_ret   <= 0;
            n_out   <= 0;
        end else begin
            n_issue <= n_issue + int'(issue);
            n_ret   <= n_ret + int'(out_credit);
            n_out   <= n_out + int'(out_valid);
        end
    end

    credit_max: assert property (@(posedge clk) disable iff (!rstn)
        credit_cnt <= CREDIT_W'(OUT_CREDITS)) else begin
        sva_errs++;
        $error("output credit count above its reset value");
    end

    // credits in use stay below the downstream room.
    issue_credit: assert property (@(posedge clk) disable iff (!rstn)
        issue |-> n_issue - n_ret < OUT_CREDITS) else begin
        sva_errs++;
        $error("issue with no output credit left");
    end

    // every result needs an earlier issue.
    out_vs_issue: assert property (@(posedge clk) disable iff (!rstn)
        out_valid |-> n_out < n_issue) else begin
        sva_errs++;
        $error("more results than issued operands");
    end

endmodule

bind fsqrt_ctrl fsqrt_sva sva_i (
    .clk        (clk),
    .rstn       (rstn),
    .issue      (issue),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .credit_cnt (credit_cnt)
);

//--- fsqrt_unit.sv
`timescale 1ns/1ps

module fsqrt_unit import fsqrt_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic            in_valid,
    input  logic [FP_W-1:0] x,
    output logic            in_credit,
    input  logic            out_credit,
    output logic            out_valid,
    output logic [FP_W-1:0] res
);

    logic            issue;
    logic [FP_W-1:0] op;

    fsqrt_ctrl ctrl_i (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .x          (x),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .issue      (issue),
        .op         (op),
        .out_valid  (out_valid)
    );

    // no handshake, result lands SQRT_LAT after issue.
    fsqrt_pipe pipe_i (
        .clk   (clk),
        .rstn  (rstn),
        .issue (issue),
        .op    (op),
        .res   (res)
    );

endmodule

//--- pipe_delay.sv
`timescale 1ns/1ps

module pipe_delay #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rstn,
    input  payload_t d,
    output payload_t q
);

    payload_t stage [DEPTH];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign q = stage[DEPTH-1];

endmodule

//--- tb_fsqrt.sv
`timescale 1ns/1ps

module tb_fsqrt import fsqrt_pkg::*; ();

    localparam int N_SQUARES    = 10;
    localparam int N_TABLE      = 14;
    localparam int N_RAND       = 200;
    localparam int N_HOLD       = 12;
    localparam int HOLD_CYC     = 40;
    localparam int N_OPS        = N_TABLE + N_RAND + N_HOLD;
    localparam int WATCHDOG_CYC = N_OPS * (SQRT_LAT + 20) + HOLD_CYC + 100;

    // operand, expected result.
    localparam logic [63:0] STIM [N_TABLE] = '{
        {32'h4080_0000, 32'h4000_0000}, // 4.0
        {32'h4110_0000, 32'h4040_0000}, // 9.0
        {32'h3E80_0000, 32'h3F00_0000}, // 0.25
        {32'h3F80_0000, 32'h3F80_0000},
        {32'h4180_0000, 32'h4080_0000},
        {32'h4980_0000, 32'h4480_0000}, // 2^20
        {32'h3580_0000, 32'h3A80_0000}, // 2^-20
        {32'h4000_0000, 32'h3FB5_04F3},
        {32'h4040_0000, 32'h3FDD_B3D7},
        {32'h4120_0000, 32'h404A_62C2}, // 10.0
        {32'h0000_0000, 32'h0000_0000},
        {32'h0000_0001, 32'h0000_0000},
        {32'h007F_FFFF, 32'h0000_0000},
        {32'h0040_0000, 32'h0000_0000}
    };

    logic            clk = 1'b0;
    logic            rstn = 1'b0;
    logic            in_valid = 1'b0;
    logic [FP_W-1:0] x = '0;
    logic            out_credit = 1'b0;
    logic            in_credit, out_valid;
    logic [FP_W-1:0] res;
    logic            has_ref = 1'b0;
    logic [FP_W-1:0] ref_val = '0;
    logic            hold_credit = 1'b0;
    logic [64:0]     pend [$]; // has_ref, ref_val, operand.
    int              up_credits, owed;
    int              n_acc, n_icr, n_res, n_err;
    int              err_mark, test_cnt;
    integer          seed = 32'hb42e;

    always #2 clk = ~clk;

    fsqrt_unit dut_i (
        .clk(clk), .rstn(rstn), .in_valid(in_valid), .x(x), .in_credit(in_credit),
        .out_credit(out_credit), .out_valid(out_valid), .res(res)
    );

    fsqrt_checker chk_i (
        .clk(clk), .rstn(rstn), .in_valid(in_valid), .x(x), .has_ref(has_ref),
        .ref_val(ref_val), .in_credit(in_credit), .out_credit(out_credit),
        .out_valid(out_valid), .res(res), .n_acc(n_acc), .n_icr(n_icr),
        .n_res(n_res), .n_err(n_err)
    );

    // a returned upstream credit can be spent right away.
    always @(posedge clk) begin : up_drive
        int avail;
        if (!rstn) begin
            up_credits <= IN_DEPTH;
            in_valid   <= 1'b0;
        end else begin
            avail = up_credits + int'(in_credit);
            if (avail > 0 && pend.size() > 0) begin
                {has_ref, ref_val, x} <= pend.pop_front();
                in_valid <= 1'b1;
                avail--;
            end else begin
                in_valid <= 1'b0;
            end
            up_credits <= avail;
        end
    end

    always @(posedge clk) begin : down_drive
        int owe;
        if (!rstn) begin
            owed       <= 0;
            out_credit <= 1'b0;
        end else begin
            owe = owed + int'(out_valid);
            if (!hold_credit && owe > 0) begin
                out_credit <= 1'b1;
                owe--;
            end else begin
                out_credit <= 1'b0;
            end
            owed <= owe;
        end
    end

    task automatic queue_op(input logic [FP_W-1:0] v, input logic use_ref,
                            input logic [FP_W-1:0] r);
        pend.push_back({use_ref, r, v});
    endtask

    function automatic logic [FP_W-1:0] rand_normal();
        logic [FP_W-1:0] v;
        v     = $random(seed);
        v[31] = 1'b0; // positive only.
        if (v[30:23] == 8'h00) v[30:23] = 8'h01;
        if (v[30:23] == 8'hFF) v[30:23] = 8'hFE;
        return v;
    endfunction

    task automatic wait_drain();
        while (pend.size() != 0 || in_valid || n_res != n_acc || n_icr != n_acc ||
               owed != 0 || out_credit) begin
            @(negedge clk);
        end
    endtask

    task automatic apply_table(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            queue_op(STIM[i][63:32], 1'b1, STIM[i][31:0]);
        end
        wait_drain();
    endtask

    task automatic report_test(input string name);
        int errs;
        errs = n_err + dut_i.ctrl_i.sva_i.sva_errs - err_mark;
        err_mark += errs;
        test_cnt++;
        $display("test %0d %s: %0d errors, %0d results so far", test_cnt, name, errs, n_res);
    endtask

    initial begin : main
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        repeat (6) @(negedge clk);
        report_test("idle after reset");
        apply_table(0, N_SQUARES - 1);
        report_test("table values");
        apply_table(N_SQUARES, N_TABLE - 1);
        report_test("zero and denormal");
        repeat (N_RAND) queue_op(rand_normal(), 1'b0, '0);
        wait_drain();
        report_test("random stream");
        hold_credit = 1'b1;
        repeat (N_HOLD) queue_op(rand_normal(), 1'b0, '0);
        repeat (HOLD_CYC) @(negedge clk);
        hold_credit = 1'b0;
        wait_drain();
        report_test("withheld output credits");
        $display("tests %0d, operands %0d, in_credit pulses %0d, results %0d, errors %0d",
                 test_cnt, n_acc, n_icr, n_res, n_err + dut_i.ctrl_i.sva_i.sva_errs);
        if (n_err + dut_i.ctrl_i.sva_i.sva_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("timeout, not all results arrived in %0d cycles", WATCHDOG_CYC);
        $display("Something failed");
        $finish;
    end

endmodule
